// ==== Bender.yml ====
package:
  name: dual_alu_core

sources:
  - include_dirs:
      - design
    files:
      - design/core_pkg.sv
      - design/lane_fwd_if.sv
      - design/issue_lane.sv
      - design/operand_forward.sv
      - design/regfile.sv
      - design/flag_select.sv
      - design/dual_alu_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/core_tb.sv

// ==== compile.f ====
+incdir+design
design/core_pkg.sv
design/lane_fwd_if.sv
design/issue_lane.sv
design/operand_forward.sv
design/regfile.sv
design/flag_select.sv
design/dual_alu_core.sv
verif/core_tb.sv

// ==== design/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// ------------------------------------------------
// Datapath sizes
// ------------------------------------------------
`define DATA_W      16
`define REG_NUM_W   3
`define NUM_REGS    8
`define INSTR_W     16

// ------------------------------------------------
// Instruction class, bits 15 to 13
// ------------------------------------------------
`define OPC_ALU     3'b101
`define OPC_MOV     3'b110

// ALU operation, bits 12 to 11
`define ALU_ADD     2'b00
`define ALU_CMP     2'b01
`define ALU_AND     2'b10
`define ALU_MVN     2'b11

// Move flavour, bits 12 to 11
`define MOV_IMM     2'b10
`define MOV_REG     2'b00

`endif

// ==== design/core_pkg.sv ====
`include "core_params.svh"

package core_pkg;

    // One instruction word, read either as a register form or an immediate form
    typedef union packed {
        // ADD, CMP, AND, MVN, MOV Rd,Rm
        struct packed {
            logic [2:0]            cls;
            logic [1:0]            op;
            logic [`REG_NUM_W-1:0] rn;
            logic [`REG_NUM_W-1:0] rd;
            logic [1:0]            unused;
            logic [`REG_NUM_W-1:0] rm;
        } r;
        // MOV Rn,#imm8
        struct packed {
            logic [2:0]            cls;
            logic [1:0]            op;
            logic [`REG_NUM_W-1:0] rn;
            logic [7:0]            imm8;
        } i;
    } instr_u;

endpackage

// ==== design/dual_alu_core.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module dual_alu_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue,
    input  logic [`INSTR_W-1:0]   lane0_instr,
    input  logic [`INSTR_W-1:0]   lane1_instr,
    output logic                  wb0_write,
    output logic [`REG_NUM_W-1:0] wb0_num,
    output logic [`DATA_W-1:0]    wb0_data,
    output logic                  wb1_write,
    output logic [`REG_NUM_W-1:0] wb1_num,
    output logic [`DATA_W-1:0]    wb1_data,
    output logic                  flag_n,
    output logic                  flag_z,
    output logic                  flag_v
);

    lane_fwd_if lane0_fwd ();
    lane_fwd_if lane1_fwd ();

    logic [`REG_NUM_W-1:0] l0_num_a, l0_num_b, l1_num_a, l1_num_b;
    logic [`DATA_W-1:0]    l0_reg_a, l0_reg_b, l1_reg_a, l1_reg_b;
    logic [`DATA_W-1:0]    l0_op_a, l0_op_b, l1_op_a, l1_op_b;
    logic                  set0, n0, z0, v0;
    logic                  set1, n1, z1, v1;

    // ------------------------------------------------
    // Lanes
    // ------------------------------------------------
    issue_lane i_lane0 (
        .clk(clk), .rst(rst), .issue(issue), .instr(lane0_instr),
        .op_a(l0_op_a), .op_b(l0_op_b), .rd_num_a(l0_num_a), .rd_num_b(l0_num_b),
        .fwd(lane0_fwd.source), .flag_set(set0), .n(n0), .z(z0), .v(v0)
    );

    issue_lane i_lane1 (
        .clk(clk), .rst(rst), .issue(issue), .instr(lane1_instr),
        .op_a(l1_op_a), .op_b(l1_op_b), .rd_num_a(l1_num_a), .rd_num_b(l1_num_b),
        .fwd(lane1_fwd.source), .flag_set(set1), .n(n1), .z(z1), .v(v1)
    );

    // ------------------------------------------------
    // Operand sourcing
    // ------------------------------------------------
    operand_forward i_fwd0 (
        .rd_num_a(l0_num_a), .rd_num_b(l0_num_b), .reg_a(l0_reg_a), .reg_b(l0_reg_b),
        .lane0(lane0_fwd.sink), .lane1(lane1_fwd.sink), .op_a(l0_op_a), .op_b(l0_op_b)
    );

    operand_forward i_fwd1 (
        .rd_num_a(l1_num_a), .rd_num_b(l1_num_b), .reg_a(l1_reg_a), .reg_b(l1_reg_b),
        .lane0(lane0_fwd.sink), .lane1(lane1_fwd.sink), .op_a(l1_op_a), .op_b(l1_op_b)
    );

    regfile i_regfile (
        .clk(clk), .rst(rst), .lane0(lane0_fwd.sink), .lane1(lane1_fwd.sink),
        .rd_num0(l0_num_a), .rd_num1(l0_num_b), .rd_num2(l1_num_a), .rd_num3(l1_num_b),
        .rd_data0(l0_reg_a), .rd_data1(l0_reg_b), .rd_data2(l1_reg_a), .rd_data3(l1_reg_b)
    );

    flag_select i_flag_select (
        .clk(clk), .rst(rst), .set0(set0), .set1(set1),
        .n0(n0), .z0(z0), .v0(v0), .n1(n1), .z1(z1), .v1(v1),
        .flag_n(flag_n), .flag_z(flag_z), .flag_v(flag_v)
    );

    // Writeback outputs mirror each lane's S3 stage
    assign wb0_write = lane0_fwd.s3_write;
    assign wb0_num   = lane0_fwd.s3_num;
    assign wb0_data  = lane0_fwd.s3_data;
    assign wb1_write = lane1_fwd.s3_write;
    assign wb1_num   = lane1_fwd.s3_num;
    assign wb1_data  = lane1_fwd.s3_data;

endmodule

// ==== design/flag_select.sv ====
`timescale 1ns/1ps

module flag_select (
    input  logic clk,
    input  logic rst,
    input  logic set0,
    input  logic set1,
    input  logic n0,
    input  logic z0,
    input  logic v0,
    input  logic n1,
    input  logic z1,
    input  logic v1,
    output logic flag_n,
    output logic flag_z,
    output logic flag_v
);

    // High when lane 1 wrote the flags last
    logic use_lane1;

    always_ff @(posedge clk) begin
        if (rst) begin
            use_lane1 <= 1'b0;
        end else if (set1) begin
            use_lane1 <= 1'b1;
        end else if (set0) begin
            use_lane1 <= 1'b0;
        end
    end

    assign flag_n = use_lane1 ? n1 : n0;
    assign flag_z = use_lane1 ? z1 : z0;
    assign flag_v = use_lane1 ? v1 : v0;

endmodule

// ==== design/issue_lane.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module issue_lane (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue,
    input  core_pkg::instr_u      instr,
    input  logic [`DATA_W-1:0]    op_a,
    input  logic [`DATA_W-1:0]    op_b,
    output logic [`REG_NUM_W-1:0] rd_num_a,
    output logic [`REG_NUM_W-1:0] rd_num_b,
    lane_fwd_if.source            fwd,
    output logic                  flag_set,
    output logic                  n,
    output logic                  z,
    output logic                  v
);

    core_pkg::instr_u      s1_instr;
    logic                  s1_valid;
    logic                  dec_write;
    logic                  dec_cmp;
    logic                  dec_pass;
    logic                  dec_imm;
    logic [`REG_NUM_W-1:0] dec_num;
    logic [`DATA_W-1:0]    imm_ext;

    logic                  s2_write;
    logic                  s2_cmp;
    logic                  s2_pass;
    logic [1:0]            s2_func;
    logic [`REG_NUM_W-1:0] s2_num;
    logic [`DATA_W-1:0]    s2_a;
    logic [`DATA_W-1:0]    s2_b;
    logic [`DATA_W-1:0]    diff;
    logic [`DATA_W-1:0]    alu_res;

    // ------------------------------------------------
    // S1: instruction register and decode
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        s1_instr <= instr;
    end

    always_comb begin
        dec_write = 1'b0;
        dec_cmp   = 1'b0;
        dec_pass  = 1'b0;
        dec_imm   = 1'b0;
        dec_num   = s1_instr.r.rd;
        case (s1_instr.r.cls)
            `OPC_ALU: begin
                dec_cmp   = (s1_instr.r.op == `ALU_CMP);
                dec_write = !dec_cmp;
            end
            `OPC_MOV: begin
                if (s1_instr.i.op == `MOV_IMM) begin
                    // Immediate form writes Rn
                    dec_imm   = 1'b1;
                    dec_pass  = 1'b1;
                    dec_write = 1'b1;
                    dec_num   = s1_instr.i.rn;
                end else if (s1_instr.r.op == `MOV_REG) begin
                    dec_pass  = 1'b1;
                    dec_write = 1'b1;
                end
            end
            default: dec_write = 1'b0;
        endcase
    end

    assign imm_ext  = {{(`DATA_W-8){s1_instr.i.imm8[7]}}, s1_instr.i.imm8};
    assign rd_num_a = s1_instr.r.rn;
    assign rd_num_b = s1_instr.r.rm;

    // ------------------------------------------------
    // S2: operand latch and ALU
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            s2_write <= 1'b0;
            s2_cmp   <= 1'b0;
        end else begin
            s2_write <= s1_valid & dec_write;
            s2_cmp   <= s1_valid & dec_cmp;
        end
    end

    always_ff @(posedge clk) begin
        s2_func <= s1_instr.r.op;
        s2_pass <= dec_pass;
        s2_num  <= dec_num;
        s2_a    <= op_a;
        s2_b    <= dec_imm ? imm_ext : op_b;
    end

    assign diff = s2_a - s2_b;

    always_comb begin
        if (s2_pass) begin
            alu_res = s2_b;
        end else begin
            case (s2_func)
                `ALU_ADD: alu_res = s2_a + s2_b;
                `ALU_AND: alu_res = s2_a & s2_b;
                `ALU_MVN: alu_res = ~s2_b;
                default:  alu_res = diff;
            endcase
        end
    end

    assign fwd.s2_write = s2_write;
    assign fwd.s2_num   = s2_num;
    assign fwd.s2_data  = alu_res;
    assign flag_set     = s2_cmp;

    // ------------------------------------------------
    // S3: writeback and lane flags
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            fwd.s3_write <= 1'b0;
            n            <= 1'b0;
            z            <= 1'b0;
            v            <= 1'b0;
        end else begin
            fwd.s3_write <= s2_write;
            if (s2_cmp) begin
                n <= diff[`DATA_W-1];
                z <= (diff == '0);
                // Overflow when signs differ and the result sign flips from Rn
                v <= (s2_a[`DATA_W-1] != s2_b[`DATA_W-1]) &&
                     (diff[`DATA_W-1] != s2_a[`DATA_W-1]);
            end
        end
    end

    always_ff @(posedge clk) begin
        fwd.s3_num  <= s2_num;
        fwd.s3_data <= alu_res;
    end

endmodule

// ==== design/lane_fwd_if.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

interface lane_fwd_if;

    // Result leaving the ALU, not yet registered
    logic                  s2_write;
    logic [`REG_NUM_W-1:0] s2_num;
    logic [`DATA_W-1:0]    s2_data;

    // Writeback stage
    logic                  s3_write;
    logic [`REG_NUM_W-1:0] s3_num;
    logic [`DATA_W-1:0]    s3_data;

    modport source (output s2_write, s2_num, s2_data, s3_write, s3_num, s3_data);
    modport sink   (input  s2_write, s2_num, s2_data, s3_write, s3_num, s3_data);

endinterface

// ==== design/operand_forward.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module operand_forward (
    input  logic [`REG_NUM_W-1:0] rd_num_a,
    input  logic [`REG_NUM_W-1:0] rd_num_b,
    input  logic [`DATA_W-1:0]    reg_a,
    input  logic [`DATA_W-1:0]    reg_b,
    lane_fwd_if.sink              lane0,
    lane_fwd_if.sink              lane1,
    output logic [`DATA_W-1:0]    op_a,
    output logic [`DATA_W-1:0]    op_b
);

    // Newest source first, lane 1 ahead of lane 0 in each stage
    function automatic logic [`DATA_W-1:0] newest(
        input logic [`REG_NUM_W-1:0] num,
        input logic [`DATA_W-1:0]    fallback
    );
        logic [`DATA_W-1:0] val;
        val = fallback;
        if (lane1.s2_write && lane1.s2_num == num) begin
            val = lane1.s2_data;
        end else if (lane0.s2_write && lane0.s2_num == num) begin
            val = lane0.s2_data;
        end else if (lane1.s3_write && lane1.s3_num == num) begin
            val = lane1.s3_data;
        end else if (lane0.s3_write && lane0.s3_num == num) begin
            val = lane0.s3_data;
        end
        return val;
    endfunction

    always_comb begin
        op_a = newest(rd_num_a, reg_a);
        op_b = newest(rd_num_b, reg_b);
    end

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module regfile (
    input  logic                  clk,
    input  logic                  rst,
    lane_fwd_if.sink              lane0,
    lane_fwd_if.sink              lane1,
    input  logic [`REG_NUM_W-1:0] rd_num0,
    input  logic [`REG_NUM_W-1:0] rd_num1,
    input  logic [`REG_NUM_W-1:0] rd_num2,
    input  logic [`REG_NUM_W-1:0] rd_num3,
    output logic [`DATA_W-1:0]    rd_data0,
    output logic [`DATA_W-1:0]    rd_data1,
    output logic [`DATA_W-1:0]    rd_data2,
    output logic [`DATA_W-1:0]    rd_data3
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    // Lane 1 is written last, so it wins on a shared target
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (lane0.s3_write) begin
                regs[lane0.s3_num] <= lane0.s3_data;
            end
            if (lane1.s3_write) begin
                regs[lane1.s3_num] <= lane1.s3_data;
            end
        end
    end

    assign rd_data0 = regs[rd_num0];
    assign rd_data1 = regs[rd_num1];
    assign rd_data2 = regs[rd_num2];
    assign rd_data3 = regs[rd_num3];

endmodule

// ==== verif/core_tb.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module core_tb;

    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = 5;
    localparam int RANDOM_PAIRS = 200;
    // Reset, move, forward, same pair and flag tests, then the random run
    localparam int TEST_CYCLES  = 17 + 15 + 28 + 18 + 25 + RANDOM_PAIRS + DRAIN_CYCLES;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + TEST_CYCLES + 50;

    typedef struct packed {
        logic                  write;
        logic [`REG_NUM_W-1:0] num;
        logic [`DATA_W-1:0]    data;
        logic                  cmp;
        logic [2:0]            nzv;
    } lane_result_t;

    typedef struct packed {
        lane_result_t lane0;
        lane_result_t lane1;
        logic [2:0]   nzv;
    } expect_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  issue;
    logic [`INSTR_W-1:0]   lane0_instr;
    logic [`INSTR_W-1:0]   lane1_instr;
    logic                  wb0_write;
    logic [`REG_NUM_W-1:0] wb0_num;
    logic [`DATA_W-1:0]    wb0_data;
    logic                  wb1_write;
    logic [`REG_NUM_W-1:0] wb1_num;
    logic [`DATA_W-1:0]    wb1_data;
    logic                  flag_n;
    logic                  flag_z;
    logic                  flag_v;

    logic [`DATA_W-1:0]    model_regs [`NUM_REGS];
    logic [2:0]            model_nzv;
    expect_t               exp_q [3];
    int                    error_count = 0;
    int                    errors_before;
    int                    tests_run = 0;
    int                    tests_passed = 0;
    int                    cycle_count = 0;
    string                 test_name;

    dual_alu_core i_dual_alu_core (
        .clk(clk), .rst(rst), .issue(issue),
        .lane0_instr(lane0_instr), .lane1_instr(lane1_instr),
        .wb0_write(wb0_write), .wb0_num(wb0_num), .wb0_data(wb0_data),
        .wb1_write(wb1_write), .wb1_num(wb1_num), .wb1_data(wb1_data),
        .flag_n(flag_n), .flag_z(flag_z), .flag_v(flag_v)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // --------------------------------------------------
    // Reference model with one delay entry per stage
    // --------------------------------------------------
    function automatic lane_result_t model_lane(input logic [`INSTR_W-1:0] word);
        core_pkg::instr_u   w;
        lane_result_t       res;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        int                 diff;
        w       = word;
        res     = '0;
        a       = model_regs[w.r.rn];
        b       = model_regs[w.r.rm];
        res.num = w.r.rd;
        if (w.r.cls == `OPC_ALU) begin
            res.write = (w.r.op != `ALU_CMP);
            case (w.r.op)
                `ALU_ADD: res.data = a + b;
                `ALU_AND: res.data = a & b;
                `ALU_MVN: res.data = ~b;
                default: begin
                    res.cmp = 1'b1;
                    diff    = $signed(a) - $signed(b);
                    res.nzv = {diff[15], diff[15:0] == 16'h0, diff > 32767 || diff < -32768};
                end
            endcase
        end else if (w.i.cls == `OPC_MOV && w.i.op == `MOV_IMM) begin
            res.write = 1'b1;
            res.num   = w.i.rn;
            res.data  = 16'($signed(w.i.imm8));
        end else if (w.r.cls == `OPC_MOV && w.r.op == `MOV_REG) begin
            res.write = 1'b1;
            res.data  = b;
        end
        return res;
    endfunction

    always @(posedge clk) begin
        expect_t e;
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                model_regs[i] = '0;
            end
            model_nzv = 3'b000;
            exp_q[0] <= '0;
            exp_q[1] <= '0;
            exp_q[2] <= '0;
        end else begin
            e = '0;
            if (issue) begin
                // Both lanes see the registers as they were before the pair
                e.lane0 = model_lane(lane0_instr);
                e.lane1 = model_lane(lane1_instr);
                if (e.lane0.write) begin
                    model_regs[e.lane0.num] = e.lane0.data;
                end
                if (e.lane1.write) begin
                    model_regs[e.lane1.num] = e.lane1.data;
                end
                if (e.lane1.cmp) begin
                    model_nzv = e.lane1.nzv;
                end else if (e.lane0.cmp) begin
                    model_nzv = e.lane0.nzv;
                end
            end
            e.nzv = model_nzv;
            exp_q[0] <= e;
            exp_q[1] <= exp_q[0];
            exp_q[2] <= exp_q[1];
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    assert property (@(posedge clk) disable iff (rst)
        wb0_write == exp_q[2].lane0.write &&
        (!wb0_write || {wb0_num, wb0_data} == {exp_q[2].lane0.num, exp_q[2].lane0.data}))
    else begin
        $display("[ERROR] %0t: lane 0 writeback %0b r%0d %h, expected %0b r%0d %h", $time,
                 $sampled(wb0_write), $sampled(wb0_num), $sampled(wb0_data),
                 $sampled(exp_q[2].lane0.write), $sampled(exp_q[2].lane0.num),
                 $sampled(exp_q[2].lane0.data));
        error_count++;
    end

    assert property (@(posedge clk) disable iff (rst)
        wb1_write == exp_q[2].lane1.write &&
        (!wb1_write || {wb1_num, wb1_data} == {exp_q[2].lane1.num, exp_q[2].lane1.data}))
    else begin
        $display("[ERROR] %0t: lane 1 writeback %0b r%0d %h, expected %0b r%0d %h", $time,
                 $sampled(wb1_write), $sampled(wb1_num), $sampled(wb1_data),
                 $sampled(exp_q[2].lane1.write), $sampled(exp_q[2].lane1.num),
                 $sampled(exp_q[2].lane1.data));
        error_count++;
    end

    assert property (@(posedge clk) disable iff (rst)
        {flag_n, flag_z, flag_v} == exp_q[2].nzv)
    else begin
        $display("[ERROR] %0t: flags nzv %b, expected %b", $time,
                 $sampled({flag_n, flag_z, flag_v}), $sampled(exp_q[2].nzv));
        error_count++;
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    function automatic logic [`INSTR_W-1:0] alu_word(input logic [1:0] op,
        input logic [2:0] rd, input logic [2:0] rn, input logic [2:0] rm);
        return {`OPC_ALU, op, rn, rd, 2'b00, rm};
    endfunction

    function automatic logic [`INSTR_W-1:0] mov_imm_word(input logic [2:0] rn,
        input logic [7:0] imm8);
        return {`OPC_MOV, `MOV_IMM, rn, imm8};
    endfunction

    function automatic logic [`INSTR_W-1:0] mov_reg_word(input logic [2:0] rd,
        input logic [2:0] rm);
        return {`OPC_MOV, `MOV_REG, 3'b000, rd, 2'b00, rm};
    endfunction

    function automatic logic [`INSTR_W-1:0] random_word();
        logic [`INSTR_W-1:0] raw;
        raw = 16'($urandom);
        case ($urandom_range(7))
            0, 1, 2, 3: raw[15:13] = `OPC_ALU;
            4: raw[15:11] = {`OPC_MOV, `MOV_IMM};
            5: raw[15:11] = {`OPC_MOV, `MOV_REG};
            6: raw[15:11] = {`OPC_MOV, raw[12], 1'b1};
            default: raw[15:13] = {raw[15], 2'b11};
        endcase
        return raw;
    endfunction

    task automatic drive_pair(input logic [`INSTR_W-1:0] word0,
        input logic [`INSTR_W-1:0] word1);
        @(posedge clk);
        issue       <= 1'b1;
        lane0_instr <= word0;
        lane1_instr <= word1;
    endtask

    // Words on the lanes are ignored while issue is low
    task automatic drive_bubble(input logic [`INSTR_W-1:0] word0,
        input logic [`INSTR_W-1:0] word1);
        @(posedge clk);
        issue       <= 1'b0;
        lane0_instr <= word0;
        lane1_instr <= word1;
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errors_before = error_count;
    endtask

    task automatic finish_test();
        repeat (DRAIN_CYCLES) drive_bubble('0, '0);
        tests_run++;
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %-18s passed", test_name);
        end else begin
            $display("test %-18s failed, %0d errors", test_name, error_count - errors_before);
        end
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic idle_after_reset();
        start_test("reset state");
        repeat (4) drive_bubble('0, '0);
        for (int r = 0; r < `NUM_REGS; r++) begin
            drive_pair(mov_reg_word(3'(r), 3'(r)), mov_reg_word(3'((r + 1) % 8), 3'(7 - r)));
        end
        finish_test();
    endtask

    task automatic move_immediates();
        start_test("move immediate");
        for (int r = 0; r < 4; r++) begin
            drive_pair(mov_imm_word(3'(r), 8'(8'h70 + 5 * r)),
                       mov_imm_word(3'(r + 4), 8'(8'h81 + 7 * r)));
        end
        drive_bubble(mov_imm_word(3'd0, 8'hAA), alu_word(`ALU_ADD, 3'd1, 3'd1, 3'd1));
        drive_pair({3'b000, 13'h1fff}, {`OPC_MOV, 2'b01, 11'h7ff});
        drive_pair({3'b111, 13'h0a5a}, mov_imm_word(3'd5, 8'hFF));
        drive_bubble(alu_word(`ALU_MVN, 3'd6, 3'd0, 3'd6), mov_imm_word(3'd2, 8'h12));
        drive_pair(mov_imm_word(3'd6, 8'h00), {`OPC_MOV, 2'b11, 11'h123});
        drive_pair(mov_reg_word(3'd1, 3'd0), mov_reg_word(3'd2, 3'd4));
        finish_test();
    endtask

    task automatic forwarding_chains();
        logic [1:0] op;
        start_test("forwarding");
        for (int r = 0; r < 4; r++) begin
            drive_pair(mov_imm_word(3'(r), 8'(8'h13 * (r + 1))),
                       mov_imm_word(3'(r + 4), 8'(8'hE1 - 8'h22 * r)));
        end
        drive_pair(alu_word(`ALU_ADD, 3'd1, 3'd0, 3'd2), alu_word(`ALU_MVN, 3'd3, 3'd0, 3'd4));
        drive_pair(alu_word(`ALU_AND, 3'd5, 3'd1, 3'd3), alu_word(`ALU_ADD, 3'd6, 3'd3, 3'd1));
        drive_pair(mov_reg_word(3'd7, 3'd1), alu_word(`ALU_ADD, 3'd0, 3'd5, 3'd3));
        drive_pair(alu_word(`ALU_MVN, 3'd2, 3'd0, 3'd6), alu_word(`ALU_AND, 3'd4, 3'd0, 3'd7));
        drive_bubble('0, '0);
        drive_pair(alu_word(`ALU_ADD, 3'd1, 3'd2, 3'd4), mov_reg_word(3'd3, 3'd2));
        drive_pair(alu_word(`ALU_ADD, 3'd1, 3'd1, 3'd1), mov_reg_word(3'd5, 3'd1));
        // Each pair reads what the two pairs before it wrote
        for (int k = 0; k < 12; k++) begin
            op = (k % 3 == 0) ? `ALU_ADD : (k % 3 == 1) ? `ALU_AND : `ALU_MVN;
            drive_pair(alu_word(op, 3'(k % 8), 3'((k + 7) % 8), 3'((k + 6) % 8)),
                       alu_word(`ALU_ADD, 3'((k + 3) % 8), 3'((k + 2) % 8), 3'((k + 5) % 8)));
        end
        finish_test();
    endtask

    task automatic same_pair_writes();
        start_test("same pair");
        drive_pair(mov_imm_word(3'd3, 8'h22), mov_imm_word(3'd6, 8'h5A));
        drive_pair(mov_imm_word(3'd3, 8'h44), mov_reg_word(3'd4, 3'd3));
        drive_pair(alu_word(`ALU_ADD, 3'd5, 3'd3, 3'd3), alu_word(`ALU_MVN, 3'd3, 3'd0, 3'd3));
        drive_pair(mov_imm_word(3'd6, 8'h33), mov_imm_word(3'd6, 8'h44));
        drive_pair(mov_reg_word(3'd7, 3'd6), alu_word(`ALU_ADD, 3'd2, 3'd6, 3'd6));
        drive_pair(mov_imm_word(3'd1, 8'h01), mov_imm_word(3'd1, 8'h02));
        drive_bubble('0, '0);
        drive_pair(mov_reg_word(3'd0, 3'd1), mov_reg_word(3'd2, 3'd6));
        drive_pair(alu_word(`ALU_AND, 3'd6, 3'd6, 3'd6), alu_word(`ALU_ADD, 3'd6, 3'd6, 3'd6));
        repeat (3) drive_bubble('0, '0);
        drive_pair(mov_reg_word(3'd0, 3'd6), mov_reg_word(3'd7, 3'd1));
        finish_test();
    endtask

    task automatic compare_flags();
        start_test("compare flags");
        drive_pair(mov_imm_word(3'd3, 8'h40), mov_imm_word(3'd1, 8'h80));
        // Doubling 0x0040 nine times gives 0x8000
        repeat (9) drive_pair(alu_word(`ALU_ADD, 3'd3, 3'd3, 3'd3), '0);
        drive_pair(alu_word(`ALU_MVN, 3'd4, 3'd0, 3'd3), mov_imm_word(3'd5, 8'h01));
        drive_pair(alu_word(`ALU_CMP, 3'd0, 3'd5, 3'd5), alu_word(`ALU_CMP, 3'd0, 3'd3, 3'd5));
        drive_pair(alu_word(`ALU_CMP, 3'd0, 3'd4, 3'd1), '0);
        drive_pair(alu_word(`ALU_ADD, 3'd2, 3'd4, 3'd5), mov_imm_word(3'd0, 8'h7F));
        drive_pair(alu_word(`ALU_AND, 3'd2, 3'd2, 3'd4), alu_word(`ALU_MVN, 3'd2, 3'd0, 3'd2));
        drive_pair('0, alu_word(`ALU_CMP, 3'd0, 3'd1, 3'd4));
        drive_pair(alu_word(`ALU_CMP, 3'd0, 3'd5, 3'd3), '0);
        drive_pair(alu_word(`ALU_CMP, 3'd0, 3'd1, 3'd5), alu_word(`ALU_CMP, 3'd0, 3'd2, 3'd2));
        drive_bubble(alu_word(`ALU_CMP, 3'd0, 3'd3, 3'd4), '0);
        drive_pair(alu_word(`ALU_CMP, 3'd0, 3'd5, 3'd4), '0);
        finish_test();
    endtask

    task automatic random_mix();
        start_test("random pairs");
        for (int k = 0; k < RANDOM_PAIRS; k++) begin
            if ($urandom_range(9) == 0) begin
                drive_bubble(random_word(), random_word());
            end else begin
                drive_pair(random_word(), random_word());
            end
        end
        finish_test();
    endtask

    // --------------------------------------------------
    // Run control
    // --------------------------------------------------
    initial begin
        void'($urandom(32'h2d51e125));
        rst         = 1'b1;
        issue       = 1'b0;
        lane0_instr = '0;
        lane1_instr = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        idle_after_reset();
        move_immediates();
        forwarding_chains();
        same_pair_writes();
        compare_flags();
        random_mix();
        $display("%0d tests run, %0d passed, %0d errors", tests_run, tests_passed, error_count);
        if (error_count == 0 && tests_passed == tests_run) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
